/* design/spi_cmd_latch.sv */
// Holds one command at a time. A new tx_req is refused until the engine has taken the last one.
`timescale 1ns/1ps

module spi_cmd_latch import spi_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   tx_req,
    input  word_t                  tx_data,
    input  logic [MODE_W-1:0]      mode,
    input  logic                   lsb_first,
    input  logic [PRESC_SEL_W-1:0] prescale,
    output logic                   tx_ack,
    output logic                   cmd_req,
    output word_t                  cmd_word,
    output logic [MODE_W-1:0]      cmd_mode,
    output logic                   cmd_lsb_first,
    output logic [PRESC_SEL_W-1:0] cmd_prescale,
    input  logic                   cmd_ack
);

    logic [LAT_STATE_W-1:0] state;
    logic                   accept;

    // A request is taken only from a clean handshake with nothing pending.
    assign accept = (state == LAT_EMPTY) && tx_req && !tx_ack;

    assign cmd_req = (state == LAT_REQ);  // Decoded straight from the state register.

    //////////////////////////////////////////////////
    // Host and engine handshakes
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tx_ack <= 1'b0;
            state  <= LAT_EMPTY;
        end else begin
            if (accept) begin
                tx_ack <= 1'b1;  // Host may change its fields from now on.
            end else if (!tx_req) begin
                tx_ack <= 1'b0;  // Closing half of the four-phase exchange.
            end

            case (state)
                LAT_EMPTY: if (accept)   state <= LAT_HELD;
                LAT_HELD:                state <= LAT_REQ;    // One cycle of settle time.
                LAT_REQ:   if (cmd_ack)  state <= LAT_DRAIN;  // Engine has started.
                LAT_DRAIN: if (!cmd_ack) state <= LAT_EMPTY;
                default:                 state <= LAT_EMPTY;
            endcase
        end
    end

    // The pending fields. They only change on accept, which needs an empty latch.
    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_word      <= tx_data;
            cmd_mode      <= mode;
            cmd_lsb_first <= lsb_first;
            cmd_prescale  <= prescale;
        end
    end

    // The engine copies the word at start, so it must not move under a live request.
    a_cmd_word_stable: assert property (@(posedge clk) disable iff (rst)
        cmd_req |=> (!cmd_req || $stable(cmd_word)))
        else $error("cmd_word changed while cmd_req was high");

endmodule

/* design/spi_master_top.sv */
// SPI master top. One word per handshake and ss rises after every word.
`timescale 1ns/1ps

module spi_master_top import spi_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    // Host transmit side.
    input  logic                   tx_req,
    input  word_t                  tx_data,
    input  logic [MODE_W-1:0]      mode,
    input  logic                   lsb_first,
    input  logic [PRESC_SEL_W-1:0] prescale,
    output logic                   tx_ack,
    // Host receive side.
    output logic                   rx_req,
    output word_t                  rx_data,
    input  logic                   rx_ack,
    // SPI pins.
    output logic                   ss,
    output logic                   sck,
    output logic                   mosi,
    input  logic                   miso
);

    // Latch to engine.
    logic                   cmd_req;
    logic                   cmd_ack;
    word_t                  cmd_word;
    logic [MODE_W-1:0]      cmd_mode;
    logic                   cmd_lsb_first;
    logic [PRESC_SEL_W-1:0] cmd_prescale;

    // Engine to receive buffer.
    logic                   word_done;
    word_t                  rx_word;
    logic                   buf_free;

    //////////////////////////////////////////////////
    // Instances
    //////////////////////////////////////////////////

    spi_cmd_latch u_cmd_latch (
        .clk           (clk),
        .rst           (rst),
        .tx_req        (tx_req),
        .tx_data       (tx_data),
        .mode          (mode),
        .lsb_first     (lsb_first),
        .prescale      (prescale),
        .tx_ack        (tx_ack),
        .cmd_req       (cmd_req),
        .cmd_word      (cmd_word),
        .cmd_mode      (cmd_mode),
        .cmd_lsb_first (cmd_lsb_first),
        .cmd_prescale  (cmd_prescale),
        .cmd_ack       (cmd_ack)
    );

    spi_shift_engine u_shift_engine (
        .clk           (clk),
        .rst           (rst),
        .cmd_req       (cmd_req),
        .cmd_word      (cmd_word),
        .cmd_mode      (cmd_mode),
        .cmd_lsb_first (cmd_lsb_first),
        .cmd_prescale  (cmd_prescale),
        .cmd_ack       (cmd_ack),
        .buf_free      (buf_free),
        .word_done     (word_done),
        .rx_word       (rx_word),
        .ss            (ss),
        .sck           (sck),
        .mosi          (mosi),
        .miso          (miso)
    );

    spi_rx_buffer u_rx_buffer (
        .clk       (clk),
        .rst       (rst),
        .word_done (word_done),
        .rx_word   (rx_word),
        .buf_free  (buf_free),
        .rx_req    (rx_req),
        .rx_data   (rx_data),
        .rx_ack    (rx_ack)
    );

endmodule

/* design/spi_pkg.sv */
// Shared constants for the SPI master. PRESC_CNT_W must equal 2**PRESC_SEL_W so the largest select fits.
package spi_pkg;

    //////////////////////////////////////////////////
    // Word and configuration widths
    //////////////////////////////////////////////////

    localparam int WORD_LEN    = 8;  // Bits shifted per transfer.
    localparam int PRESC_SEL_W = 3;  // Select p gives a half period of 2^(p+1) clk cycles.
    localparam int PRESC_CNT_W = 8;  // Wide enough for 2^(7+1)-1.
    localparam int MODE_W      = 2;  // SPI mode 0 to 3.

    // Positions of the clock phase and polarity inside the mode field.
    localparam int MODE_CPHA_BIT = 0;
    localparam int MODE_CPOL_BIT = 1;

    // The SCK progress counter holds a bit number above a one-bit phase.
    localparam int BIT_NUM_W = 4;
    localparam int SCK_CNT_W = BIT_NUM_W + 1;

    //////////////////////////////////////////////////
    // State encodings
    //////////////////////////////////////////////////

    // Command latch. The word sits in HELD for one cycle before it is offered.
    localparam int               LAT_STATE_W = 2;
    localparam logic [1:0]       LAT_EMPTY   = 2'd0;
    localparam logic [1:0]       LAT_HELD    = 2'd1;
    localparam logic [1:0]       LAT_REQ     = 2'd2;
    localparam logic [1:0]       LAT_DRAIN   = 2'd3;

    // Receive buffer.
    localparam int               BUF_STATE_W = 2;
    localparam logic [1:0]       BUF_EMPTY   = 2'd0;
    localparam logic [1:0]       BUF_OFFER   = 2'd1;  // rx_req is high.
    localparam logic [1:0]       BUF_WAIT    = 2'd2;  // Waiting for rx_ack to fall.

    typedef logic [WORD_LEN-1:0] word_t;  // One transfer word.

    // The engine counts half periods on raw and decodes them through f.
    typedef union packed {
        logic [SCK_CNT_W-1:0] raw;
        struct packed {
            logic [BIT_NUM_W-1:0] bit_num;  // Bits completed so far.
            logic                 phase;    // First or second half of the bit.
        } f;
    } sck_count_u;

endpackage

/* design/spi_rx_buffer.sv */
// Single-word receive holder. While it is full the engine will not start another word.
`timescale 1ns/1ps

module spi_rx_buffer import spi_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  word_done,
    input  word_t rx_word,
    output logic  buf_free,
    output logic  rx_req,
    output word_t rx_data,
    input  logic  rx_ack
);

    logic [BUF_STATE_W-1:0] state;

    //////////////////////////////////////////////////
    // Host receive handshake
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= BUF_EMPTY;
        end else begin
            case (state)
                BUF_EMPTY: if (word_done) state <= BUF_OFFER;  // rx_req rises next cycle.
                BUF_OFFER: if (rx_ack)    state <= BUF_WAIT;
                BUF_WAIT:  if (!rx_ack)   state <= BUF_EMPTY;  // Free only after ack falls.
                default:                  state <= BUF_EMPTY;
            endcase
        end
    end

    // The received word. The engine only finishes a word while buf_free is high.
    always_ff @(posedge clk) begin
        if (word_done) begin
            rx_data <= rx_word;
        end
    end

    assign rx_req   = (state == BUF_OFFER);
    assign buf_free = (state == BUF_EMPTY);  // Gates the next start in the engine.

    // The host may read rx_data at any cycle of the offer.
    a_rx_data_stable: assert property (@(posedge clk) disable iff (rst)
        rx_req |=> (!rx_req || $stable(rx_data)))
        else $error("rx_data changed while rx_req was high");

endmodule

/* design/spi_shift_engine.sv */
// Runs one SPI word per command with ss low for the whole word. Mode and divider are fixed at start.
`timescale 1ns/1ps

module spi_shift_engine import spi_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cmd_req,
    input  word_t                  cmd_word,
    input  logic [MODE_W-1:0]      cmd_mode,
    input  logic                   cmd_lsb_first,
    input  logic [PRESC_SEL_W-1:0] cmd_prescale,
    output logic                   cmd_ack,
    input  logic                   buf_free,
    output logic                   word_done,
    output word_t                  rx_word,
    output logic                   ss,
    output logic                   sck,
    output logic                   mosi,
    input  logic                   miso
);

    logic                   busy;         // High from start until ss rises again.
    sck_count_u             cnt;          // Half periods done in this word.
    sck_count_u             cnt_inc;
    logic [PRESC_CNT_W-1:0] presc_cnt;
    logic [PRESC_CNT_W-1:0] half_lim;     // Last count of a half period.
    logic [PRESC_SEL_W-1:0] presc_sel_r;
    logic                   cpha_r;
    logic                   cpol_r;
    logic                   lsb_r;
    word_t                  tx_sh;        // Bits still to be driven.
    word_t                  rx_sh;        // Bits sampled so far.
    word_t                  rx_shifted;
    logic                   mosi_r;
    logic                   start;
    logic                   cnt_done;
    logic                   half_end;
    logic                   last_edge;
    logic                   sample_now;

    // Drop the leading bit and fill with ones from the far end.
    function automatic word_t shift_out(input word_t w, input logic lsb);
        return lsb ? {1'b1, w[WORD_LEN-1:1]} : {w[WORD_LEN-2:0], 1'b1};
    endfunction

    function automatic logic lead_bit(input word_t w, input logic lsb);
        return lsb ? w[0] : w[WORD_LEN-1];
    endfunction

    //////////////////////////////////////////////////
    // Event decode
    //////////////////////////////////////////////////

    // Only the engine looks at buf_free, so a finished word always has a home.
    assign start = !busy && cmd_req && buf_free && !cmd_ack;

    // 2^(p+1)-1 is the all-ones mask cut down to p+1 bits.
    assign half_lim = {PRESC_CNT_W{1'b1}} >> (PRESC_SEL_W'(PRESC_CNT_W - 1) - presc_sel_r);

    assign cnt_inc.raw = cnt.raw + 1'b1;
    assign cnt_done    = (cnt.f.bit_num == BIT_NUM_W'(WORD_LEN));  // Last cycle before ss rises.
    assign half_end    = busy && !cnt_done && (presc_cnt == half_lim);
    assign last_edge   = half_end && (cnt_inc.f.bit_num == BIT_NUM_W'(WORD_LEN));
    assign sample_now  = (cnt.f.phase == cpha_r);  // Otherwise this edge drives.

    // MSB first fills from the bottom, LSB first from the top.
    assign rx_shifted = lsb_r ? {miso, rx_sh[WORD_LEN-1:1]} : {rx_sh[WORD_LEN-2:0], miso};

    //////////////////////////////////////////////////
    // Control
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy        <= 1'b0;
            ss          <= 1'b1;
            cmd_ack     <= 1'b0;
            word_done   <= 1'b0;
            cnt.raw     <= '0;
            presc_cnt   <= '0;
            presc_sel_r <= '0;
            cpha_r      <= 1'b0;
            cpol_r      <= 1'b0;  // sck rests low after reset.
            lsb_r       <= 1'b0;
        end else begin
            word_done <= last_edge;  // The buffer captures rx_word on this pulse.

            if (start) begin
                cmd_ack <= 1'b1;
            end else if (!cmd_req) begin
                cmd_ack <= 1'b0;  // Held until the latch drops its request.
            end

            if (start) begin
                busy        <= 1'b1;
                ss          <= 1'b0;
                cnt.raw     <= '0;
                presc_cnt   <= '0;
                presc_sel_r <= cmd_prescale;
                cpha_r      <= cmd_mode[MODE_CPHA_BIT];
                cpol_r      <= cmd_mode[MODE_CPOL_BIT];
                lsb_r       <= cmd_lsb_first;
            end else if (busy) begin
                if (cnt_done) begin
                    busy    <= 1'b0;
                    ss      <= 1'b1;  // Rises together with rx_req.
                    cnt.raw <= '0;
                end else if (presc_cnt == half_lim) begin
                    presc_cnt <= '0;
                    cnt       <= cnt_inc;  // sck toggles here.
                end else begin
                    presc_cnt <= presc_cnt + 1'b1;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Data path
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (start) begin
            if (cmd_mode[MODE_CPHA_BIT]) begin
                tx_sh  <= cmd_word;  // First bit goes out on the leading edge.
                mosi_r <= 1'b1;
            end else begin
                tx_sh  <= shift_out(cmd_word, cmd_lsb_first);
                mosi_r <= lead_bit(cmd_word, cmd_lsb_first);  // Valid before the first edge.
            end
        end else if (half_end) begin
            if (sample_now) begin
                rx_sh <= rx_shifted;
                if (last_edge) begin
                    rx_word <= rx_shifted;  // CPHA 1 samples its last bit on the final edge.
                end
            end else if (last_edge) begin
                rx_word <= rx_sh;  // No more bits to drive.
            end else begin
                mosi_r <= lead_bit(tx_sh, lsb_r);
                tx_sh  <= shift_out(tx_sh, lsb_r);
            end
        end
    end

    assign sck  = cnt.f.phase ^ cpol_r;  // Phase 0 is the idle level.
    assign mosi = ss ? 1'b1 : mosi_r;    // Line parks high between words.

    // The counter must be back at zero whenever the slave is deselected.
    a_sck_idle: assert property (@(posedge clk) disable iff (rst)
        ss |-> (sck == cpol_r))
        else $error("sck left its idle level while ss was high");

    // A word finishing into a full buffer would be lost.
    a_done_free: assert property (@(posedge clk) disable iff (rst)
        word_done |-> buf_free)
        else $error("word_done fired while the receive buffer was full");

endmodule

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_spi_master \
    -f sim.f -o tb_spi_master || exit 1
./obj_dir/tb_spi_master | tee /dev/stderr | grep -q "Finished with no errors" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

/* sim.f */
design/spi_pkg.sv
design/spi_cmd_latch.sv
design/spi_shift_engine.sv
design/spi_rx_buffer.sv
design/spi_master_top.sv
tb/spi_slave_model.sv
tb/tb_spi_master.sv

/* tb/spi_slave_model.sv */
// Behavioral SPI slave for simulation only. mode, lsb_first and response must settle before ss falls.
`timescale 1ns/1ps

module spi_slave_model import spi_pkg::*; (
    input  logic              ss,
    input  logic              sck,
    input  logic              mosi,
    output logic              miso,
    input  logic [MODE_W-1:0] mode,
    input  logic              lsb_first,
    input  word_t             response,
    output word_t             received
);

    logic  cpol;       // Idle level of sck for this word.
    logic  cpha;
    logic  lsb;
    logic  leading;    // The current sck edge leaves the idle level.
    word_t rec;
    int    drive_idx;  // Next response bit to put on miso.
    int    rec_idx;    // Number of mosi bits captured.

    // Bit i of a word in the order it travels on the wire.
    function automatic logic wire_bit(input word_t w, input logic l, input int i);
        return l ? w[i] : w[WORD_LEN-1-i];
    endfunction

    initial begin
        miso     = 1'b1;
        received = '0;
        forever begin
            @(negedge ss);
            cpol      = mode[MODE_CPOL_BIT];  // Configuration is frozen for the whole word.
            cpha      = mode[MODE_CPHA_BIT];
            lsb       = lsb_first;
            rec       = '0;
            rec_idx   = 0;
            drive_idx = 0;
            if (!cpha) begin
                miso      = wire_bit(response, lsb, 0);  // CPHA 0 needs bit 0 before any edge.
                drive_idx = 1;
            end
            #1;  // sck may move to a new idle level in the same step as ss falls.
            while (!ss) begin
                @(sck or ss);
                if (!ss) begin
                    leading = (sck != cpol);
                    if (leading ^ cpha) begin
                        // Sampling edge.
                        if (rec_idx < WORD_LEN) begin
                            rec = lsb ? {mosi, rec[WORD_LEN-1:1]} : {rec[WORD_LEN-2:0], mosi};
                            rec_idx++;
                        end
                    end else if (drive_idx < WORD_LEN) begin
                        miso = wire_bit(response, lsb, drive_idx);  // Driving edge.
                        drive_idx++;
                    end
                end
            end
            received = rec;   // Complete once ss is back high.
            miso     = 1'b1;
        end
    end

endmodule

/* tb/tb_spi_master.sv */
// Self-checking testbench for the SPI master. Random rows keep prescale at 3 or below.
`timescale 1ns/1ps

module tb_spi_master
    import spi_pkg::*;
();

    localparam int ROWS     = 16;
    localparam int BP_ROW   = 3;    // The row whose rx_ack is held back.
    localparam int BP_DELAY = 100;
    localparam int WORD_MAX = 2 * WORD_LEN * (2 ** (3 + 1)) + 32;  // Slowest word plus handshakes.
    localparam int WATCHDOG = ROWS * WORD_MAX + BP_DELAY + 200;

    logic                   clk, rst;
    logic                   tx_req, tx_ack, lsb_first;
    word_t                  tx_data;
    logic [MODE_W-1:0]      mode;
    logic [PRESC_SEL_W-1:0] prescale;
    logic                   rx_req, rx_ack;
    word_t                  rx_data;
    logic                   ss, sck, mosi, miso;
    logic [MODE_W-1:0]      slv_mode;
    logic                   slv_lsb;
    word_t                  slv_resp, slv_rec;

    // Stimulus and expected values, one entry per row.
    word_t                  t_tx    [ROWS];
    logic [MODE_W-1:0]      t_mode  [ROWS];
    logic                   t_lsb   [ROWS];
    logic [PRESC_SEL_W-1:0] t_presc [ROWS];
    word_t                  t_resp  [ROWS];

    int     errors;
    integer seed;
    int     rnd;
    int     row;                 // Row whose word is on the bus.
    int     half;                // Expected sck level length in clk cycles.
    int     run_len, rises;
    logic   prev_ss, prev_sck;
    logic   sent_early;

    spi_master_top u_dut (
        .clk(clk), .rst(rst), .tx_req(tx_req), .tx_data(tx_data), .mode(mode),
        .lsb_first(lsb_first), .prescale(prescale), .tx_ack(tx_ack), .rx_req(rx_req),
        .rx_data(rx_data), .rx_ack(rx_ack), .ss(ss), .sck(sck), .mosi(mosi), .miso(miso)
    );

    spi_slave_model u_slave (
        .ss(ss), .sck(sck), .mosi(mosi), .miso(miso), .mode(slv_mode),
        .lsb_first(slv_lsb), .response(slv_resp), .received(slv_rec)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic set_row(input int i, input word_t tx, input logic [MODE_W-1:0] md,
                           input logic lsb, input logic [PRESC_SEL_W-1:0] p, input word_t resp);
        t_tx[i]    = tx;
        t_mode[i]  = md;
        t_lsb[i]   = lsb;
        t_presc[i] = p;
        t_resp[i]  = resp;
    endtask

    //////////////////////////////////////////////////
    // Host handshakes
    //////////////////////////////////////////////////

    task automatic send_word(input int r);
        @(posedge clk);
        slv_mode  <= t_mode[r];  // The bus is idle, so the slave can be reconfigured.
        slv_lsb   <= t_lsb[r];
        slv_resp  <= t_resp[r];
        half      = 1 << (t_presc[r] + 1);
        tx_data   <= t_tx[r];
        mode      <= t_mode[r];
        lsb_first <= t_lsb[r];
        prescale  <= t_presc[r];
        tx_req    <= 1'b1;
        do @(posedge clk); while (!tx_ack);
        tx_req <= 1'b0;
        do @(posedge clk); while (tx_ack);
    endtask

    // Waits for the offer and checks the bus and both data words.
    task automatic take_word(input int r);
        do @(posedge clk); while (!rx_req);
        check_value($sformatf("row %0d idle ss", r), 1, ss);
        check_value($sformatf("row %0d idle mosi", r), 1, mosi);
        check_value($sformatf("row %0d idle sck", r), t_mode[r][MODE_CPOL_BIT], sck);
        check_value($sformatf("row %0d transmit", r), t_tx[r], slv_rec);
        check_value($sformatf("row %0d receive", r), t_resp[r], rx_data);
    endtask

    task automatic release_word(input logic watch_ss);
        rx_ack <= 1'b1;
        do begin
            @(posedge clk);
            if (watch_ss) begin
                check_value("back-pressure ss during rx_ack", 1, ss);
            end
        end while (rx_req);
        rx_ack <= 1'b0;
        @(posedge clk);  // The buffer frees itself on this edge.
        if (watch_ss) begin
            check_value("back-pressure ss at rx_ack release", 1, ss);
        end
    endtask

    //////////////////////////////////////////////////
    // sck monitor, sampled away from the active edge
    //////////////////////////////////////////////////

    always @(negedge clk) begin
        if (rst) begin
            prev_ss = 1'b1;
        end else if (!ss) begin
            if (prev_ss) begin
                run_len = 1;  // New word, and sck may already sit at a new idle level.
                rises   = 0;
            end else if (sck == prev_sck) begin
                run_len++;
            end else begin
                check_value($sformatf("row %0d sck level", row), half, run_len);
                run_len = 1;
                if (sck) begin
                    rises++;
                end
            end
            prev_sck = sck;
            prev_ss  = 1'b0;
        end else begin
            if (!prev_ss) begin
                check_value($sformatf("row %0d sck rises", row), WORD_LEN, rises);
            end
            prev_ss = 1'b1;
        end
    end

    initial begin
        rst = 1'b1;
        tx_req = 1'b0;
        tx_data = '0;
        mode = '0;
        lsb_first = 1'b0;
        prescale = '0;
        rx_ack = 1'b0;
        slv_mode = '0;
        slv_lsb = 1'b0;
        slv_resp = '0;
        errors = 0;
        row = 0;
        half = 2;
        sent_early = 1'b0;
        seed = 32'h66d8842a;
        set_row(0, 8'hA5, 2'd0, 1'b0, 3'd0, 8'h3C);
        set_row(1, 8'h96, 2'd1, 1'b1, 3'd1, 8'hC3);
        set_row(2, 8'h5A, 2'd2, 1'b0, 3'd3, 8'h81);
        set_row(3, 8'hF0, 2'd3, 1'b1, 3'd0, 8'h7E);
        set_row(4, 8'h01, 2'd0, 1'b1, 3'd3, 8'h80);
        set_row(5, 8'h80, 2'd1, 1'b0, 3'd0, 8'h01);
        set_row(6, 8'h33, 2'd2, 1'b1, 3'd1, 8'hE7);
        set_row(7, 8'hCC, 2'd3, 1'b0, 3'd1, 8'h18);
        for (int i = 8; i < ROWS; i++) begin
            rnd = $random(seed);
            set_row(i, rnd[7:0], rnd[9:8], rnd[10], {1'b0, rnd[12:11]}, rnd[23:16]);
        end

        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_value("reset ss", 1, ss);
        check_value("reset mosi", 1, mosi);
        check_value("reset sck", 0, sck);
        check_value("reset tx_ack", 0, tx_ack);
        check_value("reset rx_req", 0, rx_req);

        for (int r = 0; r < ROWS; r++) begin
            row = r;
            if (!sent_early) begin
                send_word(r);
            end
            sent_early = 1'b0;
            take_word(r);
            if (r == BP_ROW && r + 1 < ROWS) begin
                send_word(r + 1);  // Latched, but the full buffer keeps the engine idle.
                repeat (BP_DELAY) begin
                    @(posedge clk);
                    check_value("back-pressure ss while rx_ack is held", 1, ss);
                end
                release_word(1'b1);
                sent_early = 1'b1;
            end else begin
                release_word(1'b0);
            end
        end

        repeat (4) @(posedge clk);
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Bounds the run at the slowest word time for every row.
    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("Error: the run timed out before all rows completed");
        $display("Errors: %0d", errors);
        $display("Finished with errors");
        $finish;
    end

endmodule
